/* Makefile */
TOOL      ?= verilator
TOP       ?= tb_iq_dump
RTL_TOP   ?= iq_dump_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
design/iq_pkg.sv
design/uart_pkg.sv
design/iq_integrator.sv
design/capture_buffer.sv
design/dump_control.sv
design/uart_tx.sv
design/iq_dump_top.sv
testbench/tb_iq_dump.sv

/* design/capture_buffer.sv */
`default_nettype none

module capture_buffer #(
    parameter int  DEPTH = 256,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] addr,
    input  iq_pkg::iq_pair_t  wr_data,
    output iq_pkg::iq_pair_t  rd_data
);

    iq_pkg::iq_pair_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
        rd_data <= mem[addr]; // one cycle read latency
    end

endmodule

`default_nettype wire

/* design/dump_control.sv */
`default_nettype none

module dump_control #(
    parameter int  DEPTH = 256,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rearm,
    input  logic                 sample_valid,
    input  iq_pkg::iq_pair_t     sample,
    output logic                 wr_en,
    output logic [ADDR_W-1:0]    addr,
    output iq_pkg::iq_pair_t     wr_data,
    input  iq_pkg::iq_pair_t     rd_data,
    output logic                 tx_start,
    output uart_pkg::uart_byte_t tx_data,
    input  logic                 busy,
    output logic                 capturing,
    output logic                 dumping
);

    typedef logic [ADDR_W-1:0] addr_t;

    typedef enum logic [2:0] {
        st_capture,
        st_fetch,
        st_send_i,
        st_send_q,
        st_idle
    } state_t;

    state_t state;
    addr_t  addr_q;
    logic   wait_busy; // strobe sent, busy not yet seen
    logic   draining;
    logic   send_ok;
    logic   last_addr;

    assign draining = busy || wait_busy;
    assign send_ok = !busy && !wait_busy;
    assign last_addr = (addr_q == addr_t'(DEPTH - 1));

    assign wr_en = (state == st_capture) && sample_valid;
    assign wr_data = sample;
    assign addr = addr_q;

    assign capturing = (state == st_capture);
    // last frame still on the line counts as dumping
    assign dumping = (state == st_fetch) || (state == st_send_i) || (state == st_send_q)
                     || ((state == st_idle) && draining);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_capture;
            addr_q <= '0;
            wait_busy <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (busy) begin
                wait_busy <= 1'b0;
            end
            case (state)
                st_capture: begin
                    if (sample_valid) begin
                        if (last_addr) begin
                            addr_q <= '0;
                            state <= st_fetch;
                        end else begin
                            addr_q <= addr_t'(addr_q + 1'b1);
                        end
                    end
                end
                st_fetch: begin
                    state <= st_send_i; // rd_data valid next cycle
                end
                st_send_i: begin
                    if (send_ok) begin
                        tx_start <= 1'b1;
                        wait_busy <= 1'b1;
                        state <= st_send_q;
                    end
                end
                st_send_q: begin
                    if (send_ok) begin
                        tx_start <= 1'b1;
                        wait_busy <= 1'b1;
                        if (last_addr) begin
                            addr_q <= '0;
                            state <= st_idle;
                        end else begin
                            addr_q <= addr_t'(addr_q + 1'b1);
                            state <= st_fetch;
                        end
                    end
                end
                st_idle: begin
                    if (rearm && !draining) begin
                        state <= st_capture;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (send_ok && (state == st_send_i)) begin
            tx_data <= uart_pkg::uart_byte_t'(rd_data.i);
        end else if (send_ok && (state == st_send_q)) begin
            tx_data <= uart_pkg::uart_byte_t'(rd_data.q);
        end
    end

    start_when_idle: assert property (@(posedge clk) disable iff (reset)
        tx_start |-> !busy);

    // no write outside a capture that reset or rearm started
    write_in_capture: assert property (@(posedge clk) disable iff (reset)
        !capturing && !rearm |=> !wr_en);

endmodule

`default_nettype wire

/* design/iq_dump_top.sv */
`default_nettype none

module iq_dump_top #(
    parameter int WINDOW = 64,
    parameter int DEPTH = 256,
    parameter int CLKS_PER_BIT = 40
) (
    input  logic clk,
    input  logic reset,
    input  logic sig,
    input  logic rearm,
    output logic tx,
    output logic capturing,
    output logic dumping
);

    localparam int ADDR_W = $clog2(DEPTH);

    logic                 sample_valid;
    iq_pkg::iq_pair_t     sample;
    logic                 wr_en;
    logic [ADDR_W-1:0]    addr;
    iq_pkg::iq_pair_t     wr_data;
    iq_pkg::iq_pair_t     rd_data;
    logic                 tx_start;
    uart_pkg::uart_byte_t tx_data;
    logic                 busy;

    iq_integrator #(
        .WINDOW(WINDOW)
    ) u_iq_integrator (
        .clk(clk),
        .reset(reset),
        .sig(sig),
        .sample_valid(sample_valid),
        .sample(sample)
    );

    capture_buffer #(
        .DEPTH(DEPTH)
    ) u_capture_buffer (
        .clk(clk),
        .wr_en(wr_en),
        .addr(addr),
        .wr_data(wr_data),
        .rd_data(rd_data)
    );

    dump_control #(
        .DEPTH(DEPTH)
    ) u_dump_control (
        .clk(clk),
        .reset(reset),
        .rearm(rearm),
        .sample_valid(sample_valid),
        .sample(sample),
        .wr_en(wr_en),
        .addr(addr),
        .wr_data(wr_data),
        .rd_data(rd_data),
        .tx_start(tx_start),
        .tx_data(tx_data),
        .busy(busy),
        .capturing(capturing),
        .dumping(dumping)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_tx (
        .clk(clk),
        .reset(reset),
        .tx_start(tx_start),
        .tx_data(tx_data),
        .tx(tx),
        .busy(busy)
    );

endmodule

`default_nettype wire

/* design/iq_integrator.sv */
`default_nettype none

module iq_integrator #(
    parameter int WINDOW = 64
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             sig,
    output logic             sample_valid,
    output iq_pkg::iq_pair_t sample
);

    localparam int WIN_W = $clog2(WINDOW);
    localparam int ACC_W = WIN_W + 2; // holds +-WINDOW

    typedef logic [WIN_W-1:0] win_cnt_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    localparam acc_t PLUS_ONE = 1;
    localparam acc_t MINUS_ONE = -1;

    logic [1:0] phase;
    win_cnt_t   win_cnt;
    acc_t       acc_i;
    acc_t       acc_q;
    acc_t       sum_i;
    acc_t       sum_q;
    logic       i_pos;
    logic       q_pos;
    logic       window_end;

    // compared as int, the accumulator can be narrower than a sample
    function automatic iq_pkg::sample_t clamp(input acc_t v);
        if (int'(v) > int'(iq_pkg::SAMPLE_MAX)) begin
            return iq_pkg::SAMPLE_MAX;
        end
        if (int'(v) < int'(iq_pkg::SAMPLE_MIN)) begin
            return iq_pkg::SAMPLE_MIN;
        end
        return iq_pkg::sample_t'(v);
    endfunction

    assign i_pos = ~phase[1];          // + in phases 0 and 1
    assign q_pos = phase[1] ^ phase[0]; // + in phases 1 and 2
    assign window_end = (win_cnt == win_cnt_t'(WINDOW - 1));

    // sig is +1 when high, -1 when low
    always_comb begin
        sum_i = acc_i + ((sig == i_pos) ? PLUS_ONE : MINUS_ONE);
        sum_q = acc_q + ((sig == q_pos) ? PLUS_ONE : MINUS_ONE);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= 2'd0;
            win_cnt <= '0;
            acc_i <= '0;
            acc_q <= '0;
            sample_valid <= 1'b0;
        end else begin
            phase <= phase + 2'd1; // free running
            sample_valid <= window_end;
            if (window_end) begin
                win_cnt <= '0;
                acc_i <= '0;
                acc_q <= '0;
            end else begin
                win_cnt <= win_cnt_t'(win_cnt + 1'b1);
                acc_i <= sum_i;
                acc_q <= sum_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (window_end) begin
            sample.i <= clamp(sum_i); // includes the last bit of the window
            sample.q <= clamp(sum_q);
        end
    end

    single_strobe: assert property (@(posedge clk) disable iff (reset)
        sample_valid |=> !sample_valid);

endmodule

`default_nettype wire

/* design/iq_pkg.sv */
`default_nettype none

package iq_pkg;

    // one integrated component, I or Q
    typedef logic signed [7:0] sample_t;

    // one buffer word
    typedef struct packed {
        sample_t q;
        sample_t i;
    } iq_pair_t;

    localparam sample_t SAMPLE_MAX = 8'sd127;
    localparam sample_t SAMPLE_MIN = -8'sd128;

endpackage

`default_nettype wire

/* design/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    localparam int DATA_BITS = 8;

    // start + data + stop
    localparam int FRAME_BITS = DATA_BITS + 2;

    localparam logic START_LEVEL = 1'b0;
    localparam logic STOP_LEVEL = 1'b1; // also the idle level

    typedef logic [DATA_BITS-1:0] uart_byte_t;

endpackage

`default_nettype wire

/* design/uart_tx.sv */
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 40
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tx_start,
    input  uart_pkg::uart_byte_t tx_data,
    output logic                 tx,
    output logic                 busy
);

    localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int IDX_W = $clog2(uart_pkg::FRAME_BITS);

    typedef logic [BAUD_W-1:0] baud_cnt_t;
    typedef logic [IDX_W-1:0] bit_idx_t;

    baud_cnt_t baud_cnt;
    bit_idx_t  bit_idx;
    logic [uart_pkg::FRAME_BITS-2:0] shift; // data bits then stop
    logic      bit_done;

    assign bit_done = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            tx <= uart_pkg::STOP_LEVEL;
            busy <= 1'b0;
            baud_cnt <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (tx_start) begin
                tx <= uart_pkg::START_LEVEL;
                busy <= 1'b1;
                baud_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (bit_done) begin
            baud_cnt <= '0;
            if (bit_idx == bit_idx_t'(uart_pkg::FRAME_BITS - 1)) begin
                busy <= 1'b0; // stop bit complete
            end else begin
                tx <= shift[0];
                bit_idx <= bit_idx_t'(bit_idx + 1'b1);
            end
        end else begin
            baud_cnt <= baud_cnt_t'(baud_cnt + 1'b1);
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (!busy && tx_start) begin
            shift <= {uart_pkg::STOP_LEVEL, tx_data};
        end else if (busy && bit_done) begin
            shift <= shift >> 1;
        end
    end

    // frame must end on the stop level
    line_idle_high: assert property (@(posedge clk) disable iff (reset)
        !busy |-> tx == uart_pkg::STOP_LEVEL);

endmodule

`default_nettype wire

/* testbench/tb_iq_dump.sv */
`default_nettype none

module tb_iq_dump;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WINDOW = 256;
    localparam int DEPTH = 16;
    localparam int CLKS_PER_BIT = 8;
    localparam int FRAME_CLKS = uart_pkg::FRAME_BITS * CLKS_PER_BIT;
    localparam int CAPTURE_CLKS = (DEPTH + 2) * WINDOW; // includes settle and partial window
    localparam int DUMP_CLKS = 2 * DEPTH * (FRAME_CLKS + 3);
    localparam int IDLE_CLKS = 4 * FRAME_CLKS;
    localparam int NUM_TESTS = 5;
    localparam int TIMEOUT_CLKS = 3 * NUM_TESTS * (CAPTURE_CLKS + DUMP_CLKS + IDLE_CLKS);
    localparam int MAX_EDGES = TIMEOUT_CLKS + 16;
    localparam logic [31:0] SEED = 32'he3daca82;

    typedef enum logic [1:0] {
        mode_random,
        mode_i_half, // locked to I for 64 bits, then flat
        mode_sat     // locked to I, inverted on odd windows
    } sig_mode_t;

    logic clk;
    logic reset;
    logic sig;
    logic rearm;
    logic tx;
    logic capturing;
    logic dumping;

    sig_mode_t   mode = mode_random;
    logic        sig_hist [MAX_EDGES]; // bit driven for each active edge
    int          edge_cnt = 0;
    int          cycle_cnt = 0;
    int          err_cnt = 0;
    int          frame_cnt = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err_start = 0;
    int unsigned seed_dummy;
    logic        have_i = 1'b0;
    uart_pkg::uart_byte_t exp_bytes [$];
    iq_pkg::iq_pair_t     exp_pairs [$];

    iq_dump_top #(
        .WINDOW(WINDOW),
        .DEPTH(DEPTH),
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_iq_dump_top (
        .clk(clk),
        .reset(reset),
        .sig(sig),
        .rearm(rearm),
        .tx(tx),
        .capturing(capturing),
        .dumping(dumping)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        if (!reset) edge_cnt <= edge_cnt + 1;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CLKS) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic next_sig_bit(input int idx, input sig_mode_t m);
        logic i_pos;
        i_pos = ((idx % 4) < 2);
        case (m)
            mode_i_half: return ((idx % WINDOW) < 64) ? i_pos : 1'b1;
            mode_sat: return (((idx / WINDOW) % 2) == 0) ? i_pos : !i_pos;
            default: return ($urandom % 2) != 0;
        endcase
    endfunction

    function automatic iq_pkg::sample_t clamp_sample(input int v);
        if (v > int'(iq_pkg::SAMPLE_MAX)) return iq_pkg::SAMPLE_MAX;
        if (v < int'(iq_pkg::SAMPLE_MIN)) return iq_pkg::SAMPLE_MIN;
        return iq_pkg::sample_t'(v);
    endfunction

    // sig as +-1 times the two square waves, summed and clamped
    function automatic iq_pkg::iq_pair_t ref_pair(input logic [WINDOW-1:0] bits,
                                                  input int phase0);
        int acc_i;
        int acc_q;
        int ph;
        iq_pkg::iq_pair_t p;
        acc_i = 0;
        acc_q = 0;
        for (int k = 0; k < WINDOW; k++) begin
            ph = (phase0 + k) % 4;
            acc_i += (bits[k] == (ph == 0 || ph == 1)) ? 1 : -1;
            acc_q += (bits[k] == (ph == 1 || ph == 2)) ? 1 : -1;
        end
        p.i = clamp_sample(acc_i);
        p.q = clamp_sample(acc_q);
        return p;
    endfunction

    task automatic check_byte(input string name, input uart_pkg::uart_byte_t exp,
                              input uart_pkg::uart_byte_t got);
        if (got !== exp) begin
            $display("mismatch %s: expected 0x%02h, got 0x%02h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_pair(input string name, input iq_pkg::iq_pair_t exp,
                              input iq_pkg::iq_pair_t got);
        if (got !== exp) begin
            $display("mismatch %s: expected 0x%04h, got 0x%04h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("mismatch %s: expected 0x%01h, got 0x%01h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("error: %s", msg);
        err_cnt++;
    endtask

    initial begin
        seed_dummy = $urandom(SEED);
        sig = 1'b0;
        forever begin
            @(negedge clk);
            sig = next_sig_bit(edge_cnt, mode);
            if (edge_cnt < MAX_EDGES) sig_hist[edge_cnt] = sig;
        end
    end

    // 8N1 decoder, samples near bit centers
    initial begin : serial_decoder
        uart_pkg::uart_byte_t data;
        uart_pkg::uart_byte_t i_byte;
        iq_pkg::iq_pair_t got_pair;
        data = '0;
        i_byte = '0;
        forever begin
            @(negedge clk);
            if (!reset && tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
                if (tx !== uart_pkg::START_LEVEL) report_error("start bit ended early");
                for (int b = 0; b < uart_pkg::DATA_BITS; b++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    data[b] = tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (tx !== uart_pkg::STOP_LEVEL) report_error("bad stop bit on tx");
                frame_cnt++;
                if (exp_bytes.size() == 0) begin
                    report_error($sformatf("extra byte 0x%02h sent on tx", data));
                end else begin
                    check_byte("tx byte", exp_bytes.pop_front(), data);
                    if (!have_i) begin
                        i_byte = data;
                        have_i = 1'b1;
                    end else begin
                        got_pair.i = iq_pkg::sample_t'(i_byte);
                        got_pair.q = iq_pkg::sample_t'(data);
                        have_i = 1'b0;
                        if (exp_pairs.size() != 0) begin
                            check_pair("iq pair", exp_pairs.pop_front(), got_pair);
                        end
                    end
                end
            end
        end
    end

    task automatic begin_test();
        test_err_start = err_cnt;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt == test_err_start) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", tests_run, name, err_cnt - test_err_start);
        end
    endtask

    task automatic expect_capture(input int w0, input sig_mode_t m);
        logic [WINDOW-1:0] bits;
        iq_pkg::iq_pair_t ref_p;
        iq_pkg::iq_pair_t exp_p;
        exp_bytes.delete();
        exp_pairs.delete();
        frame_cnt = 0;
        have_i = 1'b0;
        for (int w = w0; w < w0 + DEPTH; w++) begin
            for (int k = 0; k < WINDOW; k++) bits[k] = sig_hist[w * WINDOW + k];
            ref_p = ref_pair(bits, (w * WINDOW) % 4);
            exp_p = ref_p;
            if (m == mode_i_half) begin
                exp_p.i = iq_pkg::sample_t'(64);
                exp_p.q = '0;
            end else if (m == mode_sat) begin
                exp_p.i = (w % 2 == 0) ? iq_pkg::SAMPLE_MAX : iq_pkg::SAMPLE_MIN;
                exp_p.q = '0;
            end
            exp_bytes.push_back(uart_pkg::uart_byte_t'(ref_p.i)); // I goes first
            exp_bytes.push_back(uart_pkg::uart_byte_t'(ref_p.q));
            exp_pairs.push_back(exp_p);
        end
    endtask

    task automatic finish_dump(input logic poke_rearm);
        if (poke_rearm) begin
            while (frame_cnt < DEPTH) @(negedge clk);
            rearm = 1'b1; // mid-dump, must be ignored
            @(negedge clk);
            rearm = 1'b0;
        end
        while (dumping) @(negedge clk);
        if (frame_cnt != 2 * DEPTH) begin
            report_error($sformatf("dumping fell after %0d frames", frame_cnt));
        end
        repeat (IDLE_CLKS) @(negedge clk);
        if (exp_bytes.size() != 0) begin
            report_error($sformatf("%0d expected bytes never arrived", exp_bytes.size()));
        end
        check_level("capturing", 1'b0, capturing);
        check_level("tx", 1'b1, tx);
    endtask

    task automatic rearmed_capture(input sig_mode_t m);
        int w0;
        @(posedge clk);
        mode = m;
        repeat (WINDOW + 4) @(negedge clk); // first captured window is all new mode
        rearm = 1'b1;
        w0 = edge_cnt / WINDOW; // window still open when rearm is taken
        @(negedge clk);
        rearm = 1'b0;
        check_level("capturing", 1'b1, capturing);
        while (!dumping) @(negedge clk);
        expect_capture(w0, m);
    endtask

    initial begin : test_flow
        reset = 1'b1;
        rearm = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        begin_test();
        check_level("tx", 1'b1, tx);
        while (edge_cnt <= DEPTH * WINDOW) begin
            check_level("capturing", 1'b1, capturing);
            check_level("dumping", 1'b0, dumping);
            @(negedge clk);
        end
        check_level("capturing", 1'b0, capturing);
        end_test("reset_and_capture");

        begin_test();
        expect_capture(0, mode_random);
        finish_dump(1'b1);
        end_test("random_dump_with_rearm");

        begin_test();
        rearmed_capture(mode_i_half);
        finish_dump(1'b0);
        end_test("iq_byte_order");

        begin_test();
        rearmed_capture(mode_sat);
        finish_dump(1'b0);
        end_test("saturation");

        begin_test();
        rearmed_capture(mode_random);
        finish_dump(1'b0);
        end_test("rearm_in_idle");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
